//--- rtl/soc_event_config.svh
`ifndef SOC_EVENT_CONFIG_SVH
`define SOC_EVENT_CONFIG_SVH

// event sources, gpio lines first
`define N_GPIO 8
// gpio lines plus ref clock, ref clock sits at the top index
`define N_SRC (`N_GPIO + 1)
`define EVNT_WIDTH 8
// default depth of the id buffer
`define EVT_FIFO_DEPTH 4

// apb bus widths
`define APB_ADDR_WIDTH 12
`define APB_DATA_WIDTH 32

// register map, byte offsets
`define REG_EDGE_EN 12'h000
`define REG_PENDING 12'h004
`define REG_EVT_COUNT 12'h008

`endif

//--- rtl/apb_reg_pkg.sv
`default_nettype none

`include "soc_event_config.svh"

package apb_reg_pkg;

  //////////////////////////////////////////////////
  // apb bus side types
  //////////////////////////////////////////////////

  // byte address seen by the slave
  typedef logic [`APB_ADDR_WIDTH-1:0] apb_addr_t;

  // read and write data word
  typedef logic [`APB_DATA_WIDTH-1:0] apb_data_t;

  // no strobes here, every access is a full word
  // no pready or pslverr either, slave is zero wait

endpackage

`default_nettype wire

//--- rtl/soc_event_pkg.sv
`default_nettype none

`include "soc_event_config.svh"

package soc_event_pkg;

  //////////////////////////////////////////////////
  // event side types
  //////////////////////////////////////////////////

  // one bit per source, used for enable mask and pending bits
  typedef logic [`N_SRC-1:0] src_vec_t;

  // raw gpio inputs, before sync
  typedef logic [`N_GPIO-1:0] gpio_vec_t;

  // event id handed to the cluster
  // value equals the source index
  typedef logic [`EVNT_WIDTH-1:0] evt_id_t;

  // delivered event counter, wraps
  typedef logic [31:0] evt_count_t;

endpackage

`default_nettype wire

//--- rtl/gpio_edge_producer.sv
`default_nettype none

`include "soc_event_config.svh"

module gpio_edge_producer
  import soc_event_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  gpio_vec_t gpio_i,
  input  logic      ref_clk_i,
  input  src_vec_t  edge_en_i,
  output logic      valid_o,
  output evt_id_t   id_o,
  input  logic      ready_i,
  output src_vec_t  pending_o
);

  src_vec_t src_raw;   // async sources, ref clock on top
  src_vec_t sync1_q;
  src_vec_t sync2_q;
  src_vec_t edge_q;    // previous synced level
  src_vec_t rise;
  src_vec_t set;
  src_vec_t clr;
  src_vec_t pending_q;
  evt_id_t  sel_idx;   // lowest pending index
  logic     hold_q;    // id frozen while stalled
  evt_id_t  hold_id_q;
  logic     xfer;

  assign src_raw = {ref_clk_i, gpio_i};

  //////////////////////////////////////////////////
  // sync and edge detect
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      sync1_q <= '0;
      sync2_q <= '0;
      edge_q  <= '0;
    end else begin
      sync1_q <= src_raw;
      sync2_q <= sync1_q;  // two flop sync
      edge_q  <= sync2_q;
    end
  end

  assign rise = sync2_q & ~edge_q;
  assign set  = rise & edge_en_i;  // masked at detection time

  //////////////////////////////////////////////////
  // pending bits and id select
  //////////////////////////////////////////////////

  // descending scan, last hit is the lowest index
  always_comb begin
    sel_idx = '0;
    for (int i = `N_SRC - 1; i >= 0; i--) begin
      if (pending_q[i]) begin
        sel_idx = evt_id_t'(i);
      end
    end
  end

  assign valid_o = |pending_q;
  // a lower bit arriving during a stall must not change the offered id
  assign id_o    = hold_q ? hold_id_q : sel_idx;
  assign xfer    = valid_o && ready_i;
  assign clr     = xfer ? (src_vec_t'(1) << id_o) : '0;

  // set wins over clear, a fresh edge is a new event
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pending_q <= '0;
    end else begin
      pending_q <= (pending_q & ~clr) | set;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      hold_q <= 1'b0;
    end else if (xfer) begin
      hold_q <= 1'b0;
    end else if (valid_o) begin
      hold_q <= 1'b1;  // stalled, lock id
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_o && !ready_i) begin
      hold_id_q <= id_o;
    end
  end

  assign pending_o = pending_q;

endmodule

`default_nettype wire

//--- rtl/event_fifo.sv
`default_nettype none

`include "soc_event_config.svh"

module event_fifo
  import soc_event_pkg::*;
#(
  parameter int unsigned DEPTH = `EVT_FIFO_DEPTH
) (
  input  logic    clk_i,
  input  logic    rst_n_i,
  // write side
  input  logic    valid_i,
  input  evt_id_t id_i,
  output logic    ready_o,
  // read side
  output logic    valid_o,
  output evt_id_t id_o,
  input  logic    ready_i
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  evt_id_t          mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;  // occupancy
  logic             push;
  logic             pop;

  assign ready_o = (count_q != CNT_W'(DEPTH));  // not full
  assign valid_o = (count_q != '0);             // not empty
  assign push    = valid_i && ready_o;
  assign pop     = valid_o && ready_i;
  assign id_o    = mem_q[rd_ptr_q];

  // pointer step with wrap at DEPTH
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  //////////////////////////////////////////////////
  // storage
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= id_i;
    end
  end

  //////////////////////////////////////////////////
  // pointers and count
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= ptr_next(wr_ptr_q);
      if (pop) rd_ptr_q <= ptr_next(rd_ptr_q);
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;  // idle or both
      endcase
    end
  end

endmodule

`default_nettype wire

//--- rtl/cluster_event_dispatch.sv
`default_nettype none

`include "soc_event_config.svh"

module cluster_event_dispatch
  import soc_event_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  // from fifo
  input  logic       valid_i,
  input  evt_id_t    id_i,
  output logic       ready_o,
  // cluster event port
  output logic       cl_event_valid_o,
  output evt_id_t    cl_event_data_o,
  input  logic       cl_event_ready_i,
  output evt_count_t evt_count_o
);

  logic       valid_q;
  evt_id_t    data_q;
  evt_count_t count_q;
  logic       take;     // fifo to reg
  logic       deliver;  // reg to cluster

  assign deliver = valid_q && cl_event_ready_i;
  // free slot, or slot empties this cycle
  assign ready_o = !valid_q || cl_event_ready_i;
  assign take    = valid_i && ready_o;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (take) begin
      valid_q <= 1'b1;  // refill, back to back
    end else if (deliver) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (take) begin
      data_q <= id_i;
    end
  end

  // one count per cluster handshake
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      count_q <= '0;
    end else if (deliver) begin
      count_q <= count_q + 1'b1;
    end
  end

  assign cl_event_valid_o = valid_q;
  assign cl_event_data_o  = data_q;
  assign evt_count_o      = count_q;

endmodule

`default_nettype wire

//--- rtl/apb_event_regs.sv
`default_nettype none

`include "soc_event_config.svh"

module apb_event_regs
  import apb_reg_pkg::*;
  import soc_event_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  // apb slave, zero wait
  input  apb_addr_t  paddr_i,
  input  logic       psel_i,
  input  logic       penable_i,
  input  logic       pwrite_i,
  input  apb_data_t  pwdata_i,
  output apb_data_t  prdata_o,
  // event side
  output src_vec_t   edge_en_o,
  input  src_vec_t   pending_i,
  input  evt_count_t evt_count_i
);

  logic      wr_en;
  logic      rd_en;
  src_vec_t  edge_en_q;
  apb_data_t rdata;

  // access phase only
  assign wr_en = psel_i && penable_i && pwrite_i;
  assign rd_en = psel_i && penable_i && !pwrite_i;

  //////////////////////////////////////////////////
  // write path
  //////////////////////////////////////////////////

  // only the enable mask is writable
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      edge_en_q <= '0;
    end else if (wr_en && (paddr_i == apb_addr_t'(`REG_EDGE_EN))) begin
      edge_en_q <= pwdata_i[`N_SRC-1:0];  // upper bits dropped
    end
  end

  assign edge_en_o = edge_en_q;

  //////////////////////////////////////////////////
  // read path
  //////////////////////////////////////////////////

  always_comb begin
    rdata = '0;  // unmapped reads as zero
    case (paddr_i)
      apb_addr_t'(`REG_EDGE_EN): begin
        rdata = apb_data_t'(edge_en_q);
      end
      apb_addr_t'(`REG_PENDING): begin
        rdata = apb_data_t'(pending_i);  // live view
      end
      apb_addr_t'(`REG_EVT_COUNT): begin
        rdata = apb_data_t'(evt_count_i);
      end
      default: begin
        rdata = '0;
      end
    endcase
  end

  // bus idles at zero outside a read
  assign prdata_o = rd_en ? rdata : '0;

endmodule

`default_nettype wire

//--- rtl/soc_event_unit.sv
`default_nettype none

`include "soc_event_config.svh"

module soc_event_unit
  import apb_reg_pkg::*;
  import soc_event_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  // apb config port
  input  apb_addr_t paddr_i,
  input  logic      psel_i,
  input  logic      penable_i,
  input  logic      pwrite_i,
  input  apb_data_t pwdata_i,
  output apb_data_t prdata_o,
  // event sources
  input  gpio_vec_t gpio_i,
  input  logic      ref_clk_i,
  // cluster event port
  output logic      cl_event_valid_o,
  output evt_id_t   cl_event_data_o,
  input  logic      cl_event_ready_i
);

  logic       prod_valid;  // producer to fifo
  evt_id_t    prod_id;
  logic       prod_ready;
  logic       fifo_valid;  // fifo to dispatch
  evt_id_t    fifo_id;
  logic       fifo_ready;
  src_vec_t   edge_en;
  src_vec_t   pending;
  evt_count_t evt_count;

  //////////////////////////////////////////////////
  // event path
  //////////////////////////////////////////////////

  gpio_edge_producer i_producer (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .gpio_i   (gpio_i),
    .ref_clk_i(ref_clk_i),
    .edge_en_i(edge_en),
    .valid_o  (prod_valid),
    .id_o     (prod_id),
    .ready_i  (prod_ready),
    .pending_o(pending)
  );

  event_fifo #(
    .DEPTH(`EVT_FIFO_DEPTH)
  ) i_fifo (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .valid_i(prod_valid),
    .id_i   (prod_id),
    .ready_o(prod_ready),
    .valid_o(fifo_valid),
    .id_o   (fifo_id),
    .ready_i(fifo_ready)
  );

  cluster_event_dispatch i_dispatch (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .valid_i         (fifo_valid),
    .id_i            (fifo_id),
    .ready_o         (fifo_ready),
    .cl_event_valid_o(cl_event_valid_o),
    .cl_event_data_o (cl_event_data_o),
    .cl_event_ready_i(cl_event_ready_i),
    .evt_count_o     (evt_count)
  );

  //////////////////////////////////////////////////
  // config registers
  //////////////////////////////////////////////////

  apb_event_regs i_regs (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .paddr_i    (paddr_i),
    .psel_i     (psel_i),
    .penable_i  (penable_i),
    .pwrite_i   (pwrite_i),
    .pwdata_i   (pwdata_i),
    .prdata_o   (prdata_o),
    .edge_en_o  (edge_en),
    .pending_i  (pending),    // read only view
    .evt_count_i(evt_count)
  );

endmodule

`default_nettype wire

//--- test/soc_event_unit_properties.sv
`default_nettype none

module soc_event_unit_properties
  import soc_event_pkg::*;
(
  input wire logic    clk_i,
  input wire logic    rst_n_i,
  // producer to fifo link
  input wire logic    prod_valid,
  input wire evt_id_t prod_id,
  input wire logic    prod_ready,
  // cluster port
  input wire logic    cl_event_valid_o,
  input wire evt_id_t cl_event_data_o,
  input wire logic    cl_event_ready_i
);

  timeunit 1ns;
  timeprecision 100ps;

  //////////////////////////////////////////////////
  // producer link
  //////////////////////////////////////////////////

  prod_valid_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    prod_valid && !prod_ready |=> prod_valid)
    else $error("producer dropped valid before the transfer");

  prod_id_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    prod_valid && !prod_ready |=> $stable(prod_id))
    else $error("producer id changed while stalled");

  //////////////////////////////////////////////////
  // cluster link
  //////////////////////////////////////////////////

  cl_valid_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    cl_event_valid_o && !cl_event_ready_i |=> cl_event_valid_o)
    else $error("cluster valid dropped before the transfer");

  cl_data_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    cl_event_valid_o && !cl_event_ready_i |=> $stable(cl_event_data_o))
    else $error("cluster data changed under back-pressure");

  // sync reset, so valid is cleared one edge into reset
  cl_valid_reset: assert property (@(posedge clk_i) !rst_n_i |=> !cl_event_valid_o)
    else $error("cluster valid high during reset");

endmodule

`default_nettype wire

//--- test/tb_soc_event_unit.sv
`default_nettype none

`include "soc_event_config.svh"

module tb_soc_event_unit
  import apb_reg_pkg::*;
  import soc_event_pkg::*;
;

  timeunit 1ns;
  timeprecision 100ps;

  logic clk_i, rst_n_i;
  apb_addr_t paddr_i;
  logic psel_i, penable_i, pwrite_i;
  apb_data_t pwdata_i, prdata_o;
  gpio_vec_t gpio_i;
  logic ref_clk_i;
  logic cl_event_valid_o, cl_event_ready_i;
  evt_id_t cl_event_data_o;

  integer seed;
  src_vec_t src_q;           // current source levels
  src_vec_t model_en;        // enable mask as the model sees it
  int unsigned edge_cnt [256];   // enabled rising edges per source
  int unsigned deliv_cnt [256];  // cluster transfers per id
  int unsigned obs_total;
  evt_id_t last_id;
  apb_data_t rd;
  apb_data_t r;
  int idx;

  assign gpio_i    = src_q[`N_GPIO-1:0];
  assign ref_clk_i = src_q[`N_GPIO];  // ref clock on top

  soc_event_unit uut (.*);

  bind soc_event_unit soc_event_unit_properties i_props (
    .clk_i(clk_i), .rst_n_i(rst_n_i),
    .prod_valid(prod_valid), .prod_id(prod_id), .prod_ready(prod_ready),
    .cl_event_valid_o(cl_event_valid_o), .cl_event_data_o(cl_event_data_o),
    .cl_event_ready_i(cl_event_ready_i)
  );

  always #2 clk_i = ~clk_i;  // 4 ns period

  // inputs move at the falling edge, so a valid/ready pair seen here lands at the next rise
  always begin
    @(negedge clk_i);
    #1;
    if (rst_n_i && cl_event_valid_o && cl_event_ready_i) begin
      deliv_cnt[cl_event_data_o]++;
      obs_total++;
      last_id = cl_event_data_o;
    end
  end

  //////////////////////////////////////////////////
  // checking and waiting
  //////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (exp === act) else begin
      $display("STATUS: FAIL");
      $fatal(1, "mismatch %s: expected 0x%0h, actual 0x%0h", name, exp, act);
    end
  endtask

  task automatic check_range(input string name, input int unsigned lo, input int unsigned hi,
                             input int unsigned act);
    assert (act >= lo && act <= hi) else begin
      $display("STATUS: FAIL");
      $fatal(1, "mismatch %s: expected %0d..%0d, actual %0d", name, lo, hi, act);
    end
  endtask

  task automatic report_timeout(input string what);
    $display("STATUS: FAIL");
    $fatal(1, "timed out waiting for %s", what);
  endtask

  // until the monitor sees one more transfer
  task automatic wait_transfer(input int unsigned prev, input int limit);
    int cyc;
    cyc = 0;
    while (obs_total == prev && cyc < limit) begin
      @(negedge clk_i);
      cyc++;
    end
    if (obs_total == prev) report_timeout("a cluster event");
  endtask

  // port idle for quiet_len cycles in a row
  task automatic wait_quiet(input int quiet_len, input int limit);
    int idle;
    int cyc;
    idle = 0;
    cyc  = 0;
    while (idle < quiet_len && cyc < limit) begin
      @(negedge clk_i);
      if (cl_event_valid_o) idle = 0;
      else idle++;
      cyc++;
    end
    if (idle < quiet_len) report_timeout("the event port to go idle");
  endtask

  //////////////////////////////////////////////////
  // apb and source drivers
  //////////////////////////////////////////////////

  task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
    @(negedge clk_i);
    paddr_i  = addr;
    pwdata_i = data;
    pwrite_i = 1'b1;
    psel_i   = 1'b1;  // setup phase
    @(negedge clk_i);
    penable_i = 1'b1;  // access, lands at next rise
    if (addr == `REG_EDGE_EN) model_en = data[`N_SRC-1:0];
    @(negedge clk_i);
    psel_i    = 1'b0;
    penable_i = 1'b0;
  endtask

  task automatic apb_read(input apb_addr_t addr, output apb_data_t data);
    @(negedge clk_i);
    paddr_i  = addr;
    pwrite_i = 1'b0;
    psel_i   = 1'b1;
    @(negedge clk_i);
    penable_i = 1'b1;
    #1 data = prdata_o;  // settled mid access phase
    @(negedge clk_i);
    psel_i    = 1'b0;
    penable_i = 1'b0;
  endtask

  // new levels, counts enabled rising edges
  task automatic apply_src(input src_vec_t nxt);
    for (int i = 0; i < `N_SRC; i++) begin
      if (!src_q[i] && nxt[i] && model_en[i]) edge_cnt[i]++;
    end
    src_q = nxt;
  endtask

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////

  initial begin
    seed = 32'h7f34_ff9a;
    clk_i = 1'b0;
    rst_n_i = 1'b0;
    paddr_i = '0;
    psel_i = 1'b0;
    penable_i = 1'b0;
    pwrite_i = 1'b0;
    pwdata_i = '0;
    src_q = '0;
    cl_event_ready_i = 1'b1;
    model_en = '0;
    obs_total = 0;
    repeat (16) @(negedge clk_i);
    rst_n_i = 1'b1;

    // reset state
    check_value("reset_cl_valid", 0, cl_event_valid_o);
    apb_read(`REG_EDGE_EN, rd);
    check_value("reset_edge_en", 0, rd);
    apb_read(`REG_PENDING, rd);
    check_value("reset_pending", 0, rd);
    apb_read(`REG_EVT_COUNT, rd);
    check_value("reset_evt_count", 0, rd);

    // register access, only 9 bits stick
    r = $random(seed);
    apb_write(`REG_EDGE_EN, r);
    apb_read(`REG_EDGE_EN, rd);
    check_value("edge_en_readback", r & 32'h1ff, rd);
    apb_write(12'h00c, ~r);  // unmapped
    apb_read(`REG_EDGE_EN, rd);
    check_value("edge_en_unmapped_wr", r & 32'h1ff, rd);
    apb_read(12'h00c, rd);
    check_value("unmapped_read", 0, rd);

    // one isolated edge per source, ref clock last
    for (int s = 0; s < `N_SRC; s++) begin
      apb_write(`REG_EDGE_EN, 32'h1 << s);
      r = obs_total;
      @(negedge clk_i);
      apply_src(src_vec_t'(1) << s);
      wait_transfer(r, 50);
      check_value("single_id", s, last_id);
      @(negedge clk_i);
      apply_src('0);
      wait_quiet(40, 200);
      check_value("single_count", r + 1, obs_total);  // nothing extra
    end

    // edge on a disabled source, everything else enabled
    repeat (3) begin
      idx = ($random(seed) & 32'h7fff_ffff) % `N_SRC;
      apb_write(`REG_EDGE_EN, ~(32'h1 << idx) & 32'h1ff);
      r = obs_total;
      @(negedge clk_i);
      apply_src(src_vec_t'(1) << idx);
      wait_quiet(40, 200);
      check_value("disabled_count", r, obs_total);
      apb_read(`REG_PENDING, rd);
      check_value("disabled_pending", 0, rd);
      @(negedge clk_i);
      apply_src('0);
    end

    // random traffic with back-pressure
    for (int i = 0; i < 256; i++) begin
      edge_cnt[i]  = 0;
      deliv_cnt[i] = 0;
    end
    apb_write(`REG_EDGE_EN, $random(seed));
    repeat (600) begin
      @(negedge clk_i);
      apply_src(src_q ^ src_vec_t'($random(seed) & $random(seed)));  // ~1 in 4 flips
      r = $random(seed);
      cl_event_ready_i = r[0] & r[1];  // mostly stalled, fills the fifo
    end
    @(negedge clk_i);
    apply_src('0);
    cl_event_ready_i = 1'b1;
    wait_quiet(24, 4000);
    for (int i = 0; i < 256; i++) begin
      if (edge_cnt[i] == 0) check_value($sformatf("traffic_id%0d", i), 0, deliv_cnt[i]);
      else check_range($sformatf("traffic_id%0d", i), 1, edge_cnt[i], deliv_cnt[i]);
    end

    // event count against the monitor
    apb_read(`REG_EVT_COUNT, rd);
    check_value("evt_count", obs_total, rd);
    apb_read(`REG_PENDING, rd);
    check_value("final_pending", 0, rd);

    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+rtl
rtl/apb_reg_pkg.sv
rtl/soc_event_pkg.sv
rtl/gpio_edge_producer.sv
rtl/event_fifo.sv
rtl/cluster_event_dispatch.sv
rtl/apb_event_regs.sv
rtl/soc_event_unit.sv
test/soc_event_unit_properties.sv
test/tb_soc_event_unit.sv

//--- Bender.yml
package:
  name: soc_event_unit

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/apb_reg_pkg.sv
      - rtl/soc_event_pkg.sv
      - rtl/gpio_edge_producer.sv
      - rtl/event_fifo.sv
      - rtl/cluster_event_dispatch.sv
      - rtl/apb_event_regs.sv
      - rtl/soc_event_unit.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - test/soc_event_unit_properties.sv
      - test/tb_soc_event_unit.sv
